// File: rtl/dual_port_bram.sv
// ====================
// true dual-port block RAM, read-first,
// with per-byte write masks.
// ====================
`timescale 1ns/1ps
`default_nettype none

module dual_port_bram
    import mem_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,

    input  wire logic              a_en,
    input  mem_req_t               a_req,
    output logic [DATA_WIDTH-1:0]  a_rd_data,

    input  wire logic              b_en,
    input  mem_req_t               b_req,
    output logic [DATA_WIDTH-1:0]  b_rd_data
);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    // contents start at zero in simulation.
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // one clocked block per port.

    always @(posedge clk) begin
        if (a_en) begin
            for (int k = 0; k < MASK_WIDTH; k++) begin
                if (a_req.write_mask[k]) begin
                    mem[a_req.addr][k*8 +: 8] <= a_req.data[k*8 +: 8];
                end
            end
        end
        if (reset) begin
            a_rd_data <= '0;  // read word cleared.
        end else if (a_en) begin
            a_rd_data <= mem[a_req.addr];  // old word, read-first.
        end
    end

    always @(posedge clk) begin
        if (b_en) begin
            for (int k = 0; k < MASK_WIDTH; k++) begin
                if (b_req.write_mask[k]) begin
                    mem[b_req.addr][k*8 +: 8] <= b_req.data[k*8 +: 8];
                end
            end
        end
        if (reset) begin
            b_rd_data <= '0;
        end else if (b_en) begin
            b_rd_data <= mem[b_req.addr];  // old word, read-first.
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
// ====================
// sizes, request and response types for the
// two-port memory subsystem.
// ====================
`default_nettype none

package mem_pkg;

    // memory geometry.
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;
    localparam int MASK_WIDTH = DATA_WIDTH / 8;  // one bit per byte lane.
    localparam int MEM_WORDS = 2 ** ADDR_WIDTH;

    // request queue sizing, also the sender's initial credit count.
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    // response buffering and output credits.
    localparam int RSP_BUF_DEPTH = 4;
    localparam int RSP_PTR_WIDTH = $clog2(RSP_BUF_DEPTH);
    localparam int RSP_CNT_WIDTH = $clog2(RSP_BUF_DEPTH + 1);
    localparam int RSP_CREDITS = 2;
    localparam int RSP_CREDIT_WIDTH = $clog2(RSP_CREDITS + 1);

    typedef enum logic {
        PORT_A = 1'b0,
        PORT_B = 1'b1
    } port_id_t;

    // all-zero write_mask means a plain read.
    typedef struct packed {
        logic [MASK_WIDTH-1:0] write_mask;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } mem_req_t;

    // data is the word held before the access.
    typedef struct packed {
        port_id_t              port;
        logic [DATA_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/mem_subsystem_top.sv
// ====================
// two-port memory subsystem top level.
// ====================
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import mem_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic req_a_valid,
    input  mem_req_t  req_a,
    output logic      req_a_credit,

    input  wire logic req_b_valid,
    input  mem_req_t  req_b,
    output logic      req_b_credit,

    output logic      rsp_valid,
    output mem_rsp_t  rsp,
    input  wire logic rsp_credit
);

    logic                  a_issue_valid;
    logic                  b_issue_valid;
    mem_req_t              a_issue_req;
    mem_req_t              b_issue_req;
    logic                  a_reserve_ok;
    logic                  b_reserve_ok;
    logic [DATA_WIDTH-1:0] a_rd_data;
    logic [DATA_WIDTH-1:0] b_rd_data;
    logic                  a_issue_d1;  // RAM output valid.
    logic                  b_issue_d1;
    logic                  a_issue_d2;  // response register valid.
    logic                  b_issue_d2;
    mem_rsp_t              a_rsp_next;
    mem_rsp_t              b_rsp_next;
    mem_rsp_t              a_rsp_reg;
    mem_rsp_t              b_rsp_reg;

    request_queue queue_a (
        .clk, .reset,
        .req_valid   (req_a_valid),
        .req         (req_a),
        .req_credit  (req_a_credit),
        .reserve_ok  (a_reserve_ok),
        .issue_valid (a_issue_valid),
        .issue_req   (a_issue_req)
    );

    request_queue queue_b (
        .clk, .reset,
        .req_valid   (req_b_valid),
        .req         (req_b),
        .req_credit  (req_b_credit),
        .reserve_ok  (b_reserve_ok),
        .issue_valid (b_issue_valid),
        .issue_req   (b_issue_req)
    );

    dual_port_bram bram (
        .clk, .reset,
        .a_en      (a_issue_valid),
        .a_req     (a_issue_req),
        .a_rd_data (a_rd_data),
        .b_en      (b_issue_valid),
        .b_req     (b_issue_req),
        .b_rd_data (b_rd_data)
    );

    // track each issue down the RAM and register stages.
    always_ff @(posedge clk) begin
        if (reset) begin
            a_issue_d1 <= 1'b0;
            b_issue_d1 <= 1'b0;
            a_issue_d2 <= 1'b0;
            b_issue_d2 <= 1'b0;
        end else begin
            a_issue_d1 <= a_issue_valid;
            b_issue_d1 <= b_issue_valid;
            a_issue_d2 <= a_issue_d1;
            b_issue_d2 <= b_issue_d1;
        end
    end

    assign a_rsp_next = '{port: PORT_A, data: a_rd_data};
    assign b_rsp_next = '{port: PORT_B, data: b_rd_data};

    pipe_register #(
        .payload_t   (mem_rsp_t),
        .reset_value (mem_rsp_t'(0))
    ) rsp_reg_a (
        .clk, .reset,
        .enable (a_issue_d1),
        .next   (a_rsp_next),
        .value  (a_rsp_reg)
    );

    pipe_register #(
        .payload_t   (mem_rsp_t),
        .reset_value (mem_rsp_t'(0))
    ) rsp_reg_b (
        .clk, .reset,
        .enable (b_issue_d1),
        .next   (b_rsp_next),
        .value  (b_rsp_reg)
    );

    response_merger merger (
        .clk, .reset,
        .a_issue      (a_issue_valid),
        .b_issue      (b_issue_valid),
        .a_rsp_valid  (a_issue_d2),
        .a_rsp        (a_rsp_reg),
        .b_rsp_valid  (b_issue_d2),
        .b_rsp        (b_rsp_reg),
        .a_reserve_ok (a_reserve_ok),
        .b_reserve_ok (b_reserve_ok),
        .rsp_credit   (rsp_credit),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

endmodule

`default_nettype wire

// File: rtl/pipe_register.sv
// ====================
// enabled register with synchronous reset.
// ====================
`timescale 1ns/1ps
`default_nettype none

module pipe_register #(
    parameter type payload_t = logic,
    parameter payload_t reset_value = '0
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic enable,
    input  payload_t  next,
    output payload_t  value
);

    always_ff @(posedge clk) begin
        if (reset) begin
            value <= reset_value;
        end else if (enable) begin
            value <= next;  // hold otherwise.
        end
    end

endmodule

`default_nettype wire

// File: rtl/request_queue.sv
// ====================
// per-port request FIFO with credit return
// and issue towards one RAM port.
// ====================
`timescale 1ns/1ps
`default_nettype none

module request_queue
    import mem_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic req_valid,
    input  mem_req_t  req,
    output logic      req_credit,

    input  wire logic reserve_ok,
    output logic      issue_valid,
    output mem_req_t  issue_req
);

    mem_req_t                   entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [QUEUE_CNT_WIDTH-1:0] count;
    logic                       pop;

    // issue straight from the head while the merger has room.
    assign pop = (count != '0) && reserve_ok;
    assign issue_valid = pop;
    assign issue_req = entries[rd_ptr];
    assign req_credit = pop;  // one credit back per pop.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + QUEUE_CNT_WIDTH'(req_valid) - QUEUE_CNT_WIDTH'(pop);
        end
    end

    // sender credits keep this from overflowing.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            entries[wr_ptr] <= req;
        end
    end

endmodule

`default_nettype wire

// File: rtl/response_merger.sv
// ====================
// response buffers with slot reservation and
// round-robin credit-controlled output.
// ====================
`timescale 1ns/1ps
`default_nettype none

module response_merger
    import mem_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic a_issue,
    input  wire logic b_issue,

    input  wire logic a_rsp_valid,
    input  mem_rsp_t  a_rsp,
    input  wire logic b_rsp_valid,
    input  mem_rsp_t  b_rsp,

    output logic      a_reserve_ok,
    output logic      b_reserve_ok,

    input  wire logic rsp_credit,
    output logic      rsp_valid,
    output mem_rsp_t  rsp
);

    // index 0 is port a, index 1 is port b.
    mem_rsp_t                    buf_mem [2][RSP_BUF_DEPTH];
    mem_rsp_t                    push_rsp [2];
    logic [RSP_PTR_WIDTH-1:0]    wr_ptr [2];
    logic [RSP_PTR_WIDTH-1:0]    rd_ptr [2];
    logic [RSP_CNT_WIDTH-1:0]    buf_count [2];
    logic [RSP_CNT_WIDTH-1:0]    resv_count [2];  // in flight plus buffered.
    logic [RSP_CREDIT_WIDTH-1:0] credit_count;
    logic [1:0]                  issue;
    logic [1:0]                  push;
    logic [1:0]                  pop;
    logic [1:0]                  not_empty;
    logic                        send;
    port_id_t                    rr_ptr;  // port preferred next.
    port_id_t                    sel;

    assign issue = {b_issue, a_issue};
    assign push = {b_rsp_valid, a_rsp_valid};
    assign push_rsp[0] = a_rsp;
    assign push_rsp[1] = b_rsp;

    assign a_reserve_ok = resv_count[0] < RSP_CNT_WIDTH'(RSP_BUF_DEPTH);
    assign b_reserve_ok = resv_count[1] < RSP_CNT_WIDTH'(RSP_BUF_DEPTH);

    always_comb begin
        not_empty[0] = buf_count[0] != '0;
        not_empty[1] = buf_count[1] != '0;
        sel = not_empty[rr_ptr] ? rr_ptr : port_id_t'(~rr_ptr);
        send = (credit_count != '0) && (not_empty != 2'b00);
        pop = send ? (2'b01 << sel) : 2'b00;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < 2; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                buf_count[p] <= '0;
                resv_count[p] <= '0;
            end
            credit_count <= RSP_CREDIT_WIDTH'(RSP_CREDITS);
            rr_ptr <= PORT_A;
            rsp_valid <= 1'b0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (push[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (pop[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                buf_count[p] <= buf_count[p] + RSP_CNT_WIDTH'(push[p])
                                - RSP_CNT_WIDTH'(pop[p]);
                resv_count[p] <= resv_count[p] + RSP_CNT_WIDTH'(issue[p])
                                 - RSP_CNT_WIDTH'(pop[p]);
            end
            credit_count <= credit_count + RSP_CREDIT_WIDTH'(rsp_credit)
                            - RSP_CREDIT_WIDTH'(send);
            if (send) begin
                rr_ptr <= port_id_t'(~sel);  // other port goes first next time.
            end
            rsp_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (push[p]) begin
                buf_mem[p][wr_ptr[p]] <= push_rsp[p];
            end
        end
        if (send) begin
            rsp <= buf_mem[sel][rd_ptr[sel]];  // tag already attached.
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_checks.svh
// ====================
// compare tasks and error counters for the
// memory subsystem testbench.
// ====================
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int mismatch_count = 0;
int other_error_count = 0;  // timeouts and protocol slips.

task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t expected, input string name);
    if (got !== expected) begin
        $display("MISMATCH at %0t: %s got port %0d data %h, expected port %0d data %h",
                 $time, name, got.port, got.data, expected.port, expected.data);
        mismatch_count++;
    end
endtask

task automatic check_credit_count(input int got, input int expected, input string name);
    if (got !== expected) begin
        $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, expected);
        mismatch_count++;
    end
endtask

`endif

// File: verification/mem_subsystem_tb.sv
// ====================
// testbench for the two-port memory subsystem.
// ====================
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int NUM_OPS = 22;
    localparam int SEED = 32'hc5d0;
    localparam int HOLD_START = 6;  // cycles after reset.
    localparam int HOLD_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + HOLD_CYCLES;

    typedef struct packed {
        port_id_t              port;
        logic [MASK_WIDTH-1:0] mask;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } op_t;

    // port a stays below 128, port b at 128 and above.
    localparam op_t OPS [NUM_OPS] = '{
        '{PORT_A, 4'h0, 8'h10, 32'h00000000},  // read after reset.
        '{PORT_B, 4'h0, 8'h90, 32'h00000000},
        '{PORT_A, 4'hf, 8'h10, 32'h11223344},
        '{PORT_B, 4'hf, 8'h90, 32'hcafef00d},
        '{PORT_A, 4'h0, 8'h10, 32'h00000000},
        '{PORT_B, 4'h0, 8'h90, 32'h00000000},
        '{PORT_A, 4'h5, 8'h10, 32'haabbccdd},  // bytes 0 and 2.
        '{PORT_A, 4'h0, 8'h10, 32'h00000000},
        '{PORT_B, 4'ha, 8'h90, 32'h55667788},
        '{PORT_B, 4'h1, 8'h91, 32'h000000ee},
        '{PORT_B, 4'h0, 8'h90, 32'h00000000},
        '{PORT_B, 4'h0, 8'h91, 32'h00000000},
        '{PORT_A, 4'hf, 8'h20, 32'h01020304},
        '{PORT_A, 4'hf, 8'h21, 32'h05060708},
        '{PORT_A, 4'h8, 8'h20, 32'hff000000},
        '{PORT_A, 4'h0, 8'h20, 32'h00000000},
        '{PORT_A, 4'h0, 8'h21, 32'h00000000},
        '{PORT_B, 4'hf, 8'hff, 32'hdeadbeef},
        '{PORT_B, 4'h6, 8'hff, 32'h00abcd00},
        '{PORT_B, 4'h0, 8'hff, 32'h00000000},
        '{PORT_A, 4'h0, 8'h7f, 32'h00000000},
        '{PORT_B, 4'h0, 8'h80, 32'h00000000}
    };

    logic     clk = 1'b0;
    logic     reset;
    logic     req_a_valid;
    mem_req_t req_a;
    logic     req_a_credit;
    logic     req_b_valid;
    mem_req_t req_b;
    logic     req_b_credit;
    logic     rsp_valid;
    mem_rsp_t rsp;
    logic     rsp_credit;

    `include "tb_checks.svh"

    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    mem_rsp_t exp_a [$];
    mem_rsp_t exp_b [$];
    int a_credits, b_credits, a_sent, b_sent, a_returned, b_returned;
    int rsp_credits_left;  // merger credits as seen from outside.
    int pending_credits;
    int hold_rsp_count;
    int cycle;
    int next_op;
    logic done, used_a, used_b;

    mem_subsystem_top uut (
        .clk, .reset,
        .req_a_valid (req_a_valid), .req_a (req_a), .req_a_credit (req_a_credit),
        .req_b_valid (req_b_valid), .req_b (req_b), .req_b_credit (req_b_credit),
        .rsp_valid   (rsp_valid),   .rsp   (rsp),   .rsp_credit   (rsp_credit)
    );

    always #50 clk = ~clk;

    function automatic logic in_hold();
        return cycle >= HOLD_START && cycle < HOLD_START + HOLD_CYCLES;
    endfunction

    // old word out, then the masked bytes land.
    function automatic logic [DATA_WIDTH-1:0] model_access(input mem_req_t req);
        logic [DATA_WIDTH-1:0] old;
        old = ref_mem[req.addr];
        for (int k = 0; k < MASK_WIDTH; k++) begin
            if (req.write_mask[k]) begin
                ref_mem[req.addr][k*8 +: 8] = req.data[k*8 +: 8];
            end
        end
        return old;
    endfunction

    task automatic send_entry(input op_t op);
        mem_req_t req;
        mem_rsp_t expected;
        req = '{write_mask: op.mask, addr: op.addr, data: op.data};
        expected = '{port: op.port, data: model_access(req)};
        if (op.port == PORT_A) begin
            req_a = req;
            req_a_valid = 1'b1;
            a_credits--;
            a_sent++;
            exp_a.push_back(expected);
        end else begin
            req_b = req;
            req_b_valid = 1'b1;
            b_credits--;
            b_sent++;
            exp_b.push_back(expected);
        end
    endtask

    task automatic collect_response();
        if (rsp_credits_left == 0) begin
            $display("ERROR at %0t: rsp_valid asserted without an output credit", $time);
            other_error_count++;
        end else begin
            rsp_credits_left--;
        end
        pending_credits++;
        if (in_hold()) begin
            hold_rsp_count++;
        end
        if (rsp.port == PORT_A && exp_a.size() != 0) begin
            check_rsp(rsp, exp_a.pop_front(), "rsp");
        end else if (rsp.port == PORT_B && exp_b.size() != 0) begin
            check_rsp(rsp, exp_b.pop_front(), "rsp");
        end else begin
            $display("ERROR at %0t: response on port %0d with none outstanding",
                     $time, rsp.port);
            other_error_count++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        req_a_valid = 1'b0;
        req_a = '0;
        req_b_valid = 1'b0;
        req_b = '0;
        rsp_credit = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        a_credits = QUEUE_DEPTH;
        b_credits = QUEUE_DEPTH;
        {a_sent, b_sent, a_returned, b_returned} = '0;
        rsp_credits_left = RSP_CREDITS;
        {pending_credits, hold_rsp_count, cycle, next_op} = '0;
        done = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!done && cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;  // outputs settled after the edge.
            cycle++;
            if (req_a_credit) begin
                a_credits++;
                a_returned++;
            end
            if (req_b_credit) begin
                b_credits++;
                b_returned++;
            end
            if (a_credits > QUEUE_DEPTH || b_credits > QUEUE_DEPTH) begin
                $display("ERROR at %0t: sender holds more than %0d request credits",
                         $time, QUEUE_DEPTH);
                other_error_count++;
            end
            if (rsp_valid) begin
                collect_response();
            end
            req_a_valid = 1'b0;
            req_b_valid = 1'b0;
            rsp_credit = 1'b0;
            if (pending_credits > 0 && !in_hold() && ($urandom % 2 == 1)) begin
                rsp_credit = 1'b1;
                pending_credits--;
                rsp_credits_left++;
            end
            used_a = 1'b0;
            used_b = 1'b0;
            // up to one entry per port each cycle, in table order.
            repeat (2) begin
                if (next_op < NUM_OPS) begin
                    if (OPS[next_op].port == PORT_A && !used_a && a_credits > 0) begin
                        send_entry(OPS[next_op]);
                        used_a = 1'b1;
                        next_op++;
                    end else if (OPS[next_op].port == PORT_B && !used_b && b_credits > 0) begin
                        send_entry(OPS[next_op]);
                        used_b = 1'b1;
                        next_op++;
                    end
                end
            end
            done = next_op == NUM_OPS && exp_a.size() == 0 && exp_b.size() == 0;
        end
        if (!done) begin
            $display("ERROR: timeout after %0d cycles, %0d of %0d entries sent", cycle,
                     next_op, NUM_OPS);
            other_error_count++;
        end else begin
            check_credit_count(a_returned, a_sent, "req_a_credit returns");
            check_credit_count(b_returned, b_sent, "req_b_credit returns");
            check_credit_count(a_credits, QUEUE_DEPTH, "port a sender credits");
            check_credit_count(b_credits, QUEUE_DEPTH, "port b sender credits");
            if (hold_rsp_count > RSP_CREDITS) begin
                $display("ERROR: %0d responses arrived while rsp_credit was withheld",
                         hold_rsp_count);
                other_error_count++;
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                 other_error_count);
        if (mismatch_count + other_error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verification
rtl/mem_pkg.sv
rtl/pipe_register.sv
rtl/dual_port_bram.sv
rtl/request_queue.sv
rtl/response_merger.sv
rtl/mem_subsystem_top.sv
verification/mem_subsystem_tb.sv
